/* verif/snake_testdata.txt */
# Columns: test action count head_x head_y score length started game_over
# Actions: reset, right press, left press, tick with a count of game ticks
reset_state  reset  0   8  40  0  6  0  0
start        reset  0   8  40  0  6  0  0
start        right  1   8  40  0  6  1  0
start        tick   1   9  40  1  7  1  0
straight     reset  0   8  40  0  6  0  0
straight     right  1   8  40  0  6  1  0
straight     tick   1   9  40  1  7  1  0
straight     tick   1  10  40  1  7  1  0
straight     tick   2  12  40  1  7  1  0
turns        reset  0   8  40  0  6  0  0
turns        right  1   8  40  0  6  1  0
turns        tick   1   9  40  1  7  1  0
turns        right  1   9  40  1  7  1  0
turns        tick   1   9  41  1  7  1  0
turns        left   1   9  41  1  7  1  0
turns        tick   1  10  41  1  7  1  0
wall         reset  0   8  40  0  6  0  0
wall         right  1   8  40  0  6  1  0
wall         left   1   8  40  0  6  1  0
wall         tick  39   8   1  0  6  1  0
wall         tick   1   8   0  0  6  0  1
restart      reset  0   8  40  0  6  0  0
restart      right  1   8  40  0  6  1  0
restart      left   1   8  40  0  6  1  0
restart      tick  40   8   0  0  6  0  1
restart      right  1   8  40  0  6  0  0

/* project.f */
+incdir+include
src/snake_pkg.sv
src/button_sync.sv
src/snake_control.sv
src/snake_steering.sv
src/snake_body.sv
src/fruit_keeper.sv
src/snake_game_top.sv
verif/snake_game_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the snake game testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module snake_game_tb -f project.f -o snake_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/snake_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F 'All tests passed!' "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* verif/snake_game_tb.sv */
// Testbench for the snake game core
// Reads test steps and expected values from the test data file
// Drives turn buttons and game ticks, checks head, score, length and status
// One result line per test, totals at the end
`timescale 1ns/1ps
`default_nettype none

`include "snake_cfg.svh"

module snake_game_tb;

    import snake_pkg::*;

    localparam int TICK_GAP    = 12;    // Cycles from tick strobe to next action, at least
    localparam int MOVE_LIMIT  = 8;     // Tick to head step
    localparam int PLACE_LIMIT = 300;   // Fruit redraw cycles

    logic                       clock_25;
    logic                       reset;
    logic                       turn_right_button;
    logic                       turn_left_button;
    logic                       game_tick;
    cell_t                      head;
    cell_t                      fruit;
    logic [`SNAKE_LEN_BITS-1:0] length;
    logic [6:0]                 score;
    logic                       started;
    logic                       game_over;

    string test_name;       // Test in progress
    int    test_errors;
    int    error_count;
    int    tests_run;
    int    tests_failed;
    bit    timed_out;       // Stops the run after a hung wait

    snake_game_top snake_game_top_i (
        .clock_25          (clock_25),
        .reset             (reset),
        .turn_right_button (turn_right_button),
        .turn_left_button  (turn_left_button),
        .game_tick         (game_tick),
        .head              (head),
        .fruit             (fruit),
        .length            (length),
        .score             (score),
        .started           (started),
        .game_over         (game_over)
    );

    initial begin
        clock_25 = 1'b0;
        forever #5 clock_25 = ~clock_25;    // 10 ns period
    end

    task automatic compare_value(input string what, input int expected, input int actual);
        if (expected !== actual) begin
            $display("Error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in test %s: %s", test_name, what);
        timed_out = 1'b1;
        test_errors++;
        error_count++;
    endtask

    // Reset low for 2 cycles, then room for RESET_IDLE
    task automatic reset_dut();
        @(posedge clock_25);
        reset             <= 1'b0;
        turn_right_button <= 1'b0;
        turn_left_button  <= 1'b0;
        game_tick         <= 1'b0;
        repeat (2) @(posedge clock_25);
        reset <= 1'b1;
        repeat (4) @(posedge clock_25);
    endtask

    task automatic press_button(input bit right_side);
        @(posedge clock_25);
        if (right_side) turn_right_button <= 1'b1;
        else            turn_left_button  <= 1'b1;
        repeat (3) @(posedge clock_25);                 // Held 3 cycles
        turn_right_button <= 1'b0;
        turn_left_button  <= 1'b0;
        repeat (3) @(posedge clock_25);                 // Released 3 cycles
    endtask

    task automatic pulse_game_tick();
        cell_t      head_before;
        cell_t      fruit_before;
        cell_t      fruit_prev;
        logic [6:0] score_before;
        int         cycles;
        bit         settled;
        head_before  = head;
        fruit_before = fruit;
        score_before = score;
        @(posedge clock_25);
        game_tick <= 1'b1;
        @(posedge clock_25);
        game_tick <= 1'b0;                              // Sampled in WAIT here
        cycles = 1;
        while (head == head_before && cycles <= MOVE_LIMIT) begin
            @(negedge clock_25);
            cycles++;
        end
        if (head == head_before) begin
            report_timeout("head did not move after a game tick");
        end else begin
            repeat (2) @(negedge clock_25);             // MOVE_DONE, then grow edge
            cycles += 2;
            settled = 1'b0;
            // Fruit changes every cycle while a redraw is running
            for (int n = 0; n < PLACE_LIMIT && !settled; n++) begin
                fruit_prev = fruit;
                @(negedge clock_25);
                cycles++;
                settled = (fruit == fruit_prev);
            end
            if (!settled) begin
                report_timeout("fruit placement never settled");
            end else begin
                if (score != score_before) begin
                    // New fruit must be a legal free cell
                    compare_value("fruit x in field", 1,
                                  (int'(fruit.x) < `SNAKE_GRID_W - 1) ? 1 : 0);
                    compare_value("fruit y in field", 1,
                                  (int'(fruit.y) < `SNAKE_GRID_H - 1) ? 1 : 0);
                    compare_value("fruit off head", 1, (fruit != head) ? 1 : 0);
                    compare_value("fruit moved", 1, (fruit != fruit_before) ? 1 : 0);
                end
                while (cycles < TICK_GAP) begin
                    @(posedge clock_25);
                    cycles++;
                end
            end
        end
    endtask

    task automatic check_outputs(input int exp_hx, input int exp_hy, input int exp_score,
                                 input int exp_len, input int exp_started, input int exp_over);
        @(negedge clock_25);                            // Outputs settled
        compare_value("head x", exp_hx, int'(head.x));
        compare_value("head y", exp_hy, int'(head.y));
        compare_value("score", exp_score, int'(score));
        compare_value("length", exp_len, int'(length));
        compare_value("started", exp_started, int'(started));
        compare_value("game_over", exp_over, int'(game_over));
        if (exp_started == 0 && exp_over == 0) begin
            // Idle always follows a restart, fruit back at its start cell
            compare_value("fruit x", `FRUIT_START_X, int'(fruit.x));
            compare_value("fruit y", `FRUIT_START_Y, int'(fruit.y));
        end
    endtask

    task automatic report_test();
        if (test_name != "") begin
            if (test_errors == 0) begin
                $display("PASS %s", test_name);
            end else begin
                $display("FAIL %s with %0d errors", test_name, test_errors);
                tests_failed++;
            end
        end
    endtask

    initial begin
        int    fd;
        int    fields;
        string line_text;
        string name;
        string action;
        int    count;
        int    exp_hx;
        int    exp_hy;
        int    exp_score;
        int    exp_len;
        int    exp_started;
        int    exp_over;
        reset             = 1'b0;                       // Held low from time zero
        turn_right_button = 1'b0;
        turn_left_button  = 1'b0;
        game_tick         = 1'b0;
        test_name         = "";
        test_errors       = 0;
        error_count       = 0;
        tests_run         = 0;
        tests_failed      = 0;
        timed_out         = 1'b0;
        repeat (2) @(posedge clock_25);
        reset <= 1'b1;

        fd = $fopen("verif/snake_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/snake_testdata.txt");
            error_count++;
        end else begin
            while (!timed_out && $fgets(line_text, fd) != 0) begin
                fields = $sscanf(line_text, "%s %s %d %d %d %d %d %d %d", name, action,
                                 count, exp_hx, exp_hy, exp_score, exp_len, exp_started,
                                 exp_over);
                if (fields == 9) begin                  // Comment and blank lines skipped
                    if (name != test_name) begin
                        report_test();
                        test_name   = name;
                        test_errors = 0;
                        tests_run++;
                        if (action != "reset") reset_dut();
                    end
                    if (action == "reset") begin
                        reset_dut();
                    end else if (action == "right") begin
                        for (int i = 0; i < count; i++) press_button(1'b1);
                    end else if (action == "left") begin
                        for (int i = 0; i < count; i++) press_button(1'b0);
                    end else if (action == "tick") begin
                        for (int i = 0; i < count && !timed_out; i++) pulse_game_tick();
                    end else begin
                        $display("Unknown action %s in test %s", action, test_name);
                        test_errors++;
                        error_count++;
                    end
                    if (!timed_out) begin
                        check_outputs(exp_hx, exp_hy, exp_score, exp_len, exp_started,
                                      exp_over);
                    end
                end
            end
            $fclose(fd);
            report_test();
            if (tests_run == 0) begin
                $display("No test steps were read from the test data file");
                error_count++;
            end
        end

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/snake_game_top.sv */
// Snake game core top level
// Buttons, FSM, steering, body store and fruit keeper
`timescale 1ns/1ps
`default_nettype none

`include "snake_cfg.svh"

module snake_game_top (
    input  wire                        clock_25,
    input  wire                        reset,
    input  wire                        turn_right_button,
    input  wire                        turn_left_button,
    input  wire                        game_tick,
    output snake_pkg::cell_t           head,
    output snake_pkg::cell_t           fruit,
    output logic [`SNAKE_LEN_BITS-1:0] length,
    output logic [6:0]                 score,
    output logic                       started,
    output logic                       game_over
);

    import snake_pkg::*;

    turn_t      presses;    // Edge strobes
    game_ctrl_t ctrl;       // FSM strobes
    heading_t   heading;
    cell_t      neck;
    cell_t      query;      // Fruit cell under test
    logic       head_crash;
    logic       occupied;
    logic       fruit_hit;
    logic       fruit_bad;

    button_sync button_sync_i (
        .clock_25          (clock_25),
        .reset             (reset),
        .turn_right_button (turn_right_button),
        .turn_left_button  (turn_left_button),
        .presses           (presses)
    );

    snake_control snake_control_i (
        .clock_25   (clock_25),
        .reset      (reset),
        .presses    (presses),
        .game_tick  (game_tick),
        .head_crash (head_crash),
        .fruit_hit  (fruit_hit),
        .fruit_bad  (fruit_bad),
        .ctrl       (ctrl),
        .started    (started),
        .game_over  (game_over)
    );

    snake_steering snake_steering_i (
        .clock_25 (clock_25),
        .reset    (reset),
        .presses  (presses),
        .ctrl     (ctrl),
        .started  (started),
        .head     (head),
        .neck     (neck),
        .heading  (heading)
    );

    snake_body snake_body_i (
        .clock_25   (clock_25),
        .reset      (reset),
        .ctrl       (ctrl),
        .heading    (heading),
        .head       (head),
        .neck       (neck),
        .length     (length),
        .head_crash (head_crash),
        .query      (query),
        .occupied   (occupied)
    );

    fruit_keeper fruit_keeper_i (
        .clock_25  (clock_25),
        .reset     (reset),
        .ctrl      (ctrl),
        .head      (head),
        .occupied  (occupied),
        .query     (query),
        .fruit     (fruit),
        .fruit_hit (fruit_hit),
        .fruit_bad (fruit_bad),
        .score     (score)
    );

endmodule

`default_nettype wire

/* src/fruit_keeper.sv */
// Fruit position and score
// Two free-running 7-bit LFSRs for candidate cells
// Placement check against the snake and the field, fruit hit
`timescale 1ns/1ps
`default_nettype none

`include "snake_cfg.svh"

module fruit_keeper (
    input  wire                        clock_25,
    input  wire                        reset,
    input  wire snake_pkg::game_ctrl_t ctrl,
    input  wire snake_pkg::cell_t      head,
    input  wire                        occupied,
    output snake_pkg::cell_t           query,
    output snake_pkg::cell_t           fruit,
    output logic                       fruit_hit,
    output logic                       fruit_bad,
    output logic [6:0]                 score
);

    import snake_pkg::*;

    localparam int CB = `SNAKE_COORD_BITS;

    logic [CB-1:0] lfsr_x;
    logic [CB-1:0] lfsr_y;
    cell_t         candidate;

    // x^7 + x^6 + 1 with period 127
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            lfsr_x <= CB'(`FRUIT_SEED_X);
            lfsr_y <= CB'(`FRUIT_SEED_Y);
        end else begin
            lfsr_x <= {lfsr_x[CB-2:0], lfsr_x[6] ^ lfsr_x[5]};
            lfsr_y <= {lfsr_y[CB-2:0], lfsr_y[6] ^ lfsr_y[5]};
        end
    end

    assign candidate = {lfsr_x, lfsr_y};

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            fruit.x <= CB'(`FRUIT_START_X);
            fruit.y <= CB'(`FRUIT_START_Y);
            score   <= '0;
        end else if (ctrl.restart) begin
            fruit.x <= CB'(`FRUIT_START_X);             // New game
            fruit.y <= CB'(`FRUIT_START_Y);
            score   <= '0;
        end else if (ctrl.grow) begin
            fruit <= candidate;                         // First draw checked in place
            if (score == 7'(`SCORE_WRAP)) score <= '0;
            else                          score <= score + 7'd1;
        end else if (ctrl.place && fruit_bad) begin
            fruit <= candidate;                         // Redraw
        end
    end

    assign query = fruit;                               // Snake body answers occupied

    // Last row and column are excluded as well
    assign fruit_bad = occupied ||
                       (fruit.x >= CB'(`SNAKE_GRID_W - 1)) ||
                       (fruit.y >= CB'(`SNAKE_GRID_H - 1));

    assign fruit_hit = (fruit == head);

    // Placement done means a legal cell inside the field
    fruit_in_field_a: assert property (@(posedge clock_25) disable iff (!reset)
        $fell(ctrl.place) |-> (fruit.x < CB'(`SNAKE_GRID_W - 1)) &&
                              (fruit.y < CB'(`SNAKE_GRID_H - 1)) && (fruit != head));

endmodule

`default_nettype wire

/* src/snake_body.sv */
// Snake head and body store
// Head step with border clamp, body shift up to the length
// Wall and self collision, occupancy lookup for fruit placement
`timescale 1ns/1ps
`default_nettype none

`include "snake_cfg.svh"

module snake_body (
    input  wire                        clock_25,
    input  wire                        reset,
    input  wire snake_pkg::game_ctrl_t ctrl,
    input  wire snake_pkg::heading_t   heading,
    output snake_pkg::cell_t           head,
    output snake_pkg::cell_t           neck,
    output logic [`SNAKE_LEN_BITS-1:0] length,
    output logic                       head_crash,
    input  wire snake_pkg::cell_t      query,
    output logic                       occupied
);

    import snake_pkg::*;

    localparam int CB     = `SNAKE_COORD_BITS;
    localparam int SEGS   = `SNAKE_LEN_MAX - 1;         // Cells behind the head
    localparam int X_LAST = `SNAKE_GRID_W - 1;
    localparam int Y_LAST = `SNAKE_GRID_H - 1;

    cell_t segs [SEGS];     // segs[0] is the neck
    cell_t head_step;
    logic  self_hit;
    logic  wall_hit;

    // Next head cell clamped at the border
    always_comb begin
        head_step = head;
        case (heading)
            HEAD_UP:    if (head.y != '0)         head_step.y = head.y - CB'(1);
            HEAD_DOWN:  if (head.y != CB'(Y_LAST)) head_step.y = head.y + CB'(1);
            HEAD_LEFT:  if (head.x != '0)         head_step.x = head.x - CB'(1);
            HEAD_RIGHT: if (head.x != CB'(X_LAST)) head_step.x = head.x + CB'(1);
            default:    head_step = head;
        endcase
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            head.x <= CB'(`SNAKE_START_X);
            head.y <= CB'(`SNAKE_START_Y);
            length <= `SNAKE_LEN_BITS'(`SNAKE_START_LEN);
        end else if (ctrl.restart) begin
            head.x <= CB'(`SNAKE_START_X);              // New game
            head.y <= CB'(`SNAKE_START_Y);
            length <= `SNAKE_LEN_BITS'(`SNAKE_START_LEN);
        end else begin
            if (ctrl.move) head <= head_step;
            if (ctrl.grow && length != `SNAKE_LEN_BITS'(`SNAKE_LEN_MAX))
                length <= length + `SNAKE_LEN_BITS'(1); // Saturate at max
        end
    end

    // Body cells laid out by restart
    always_ff @(posedge clock_25) begin
        if (ctrl.restart) begin
            for (int i = 0; i < SEGS; i++) begin
                if (i < `SNAKE_START_LEN - 1) begin
                    segs[i].x <= CB'(`SNAKE_START_X - 1 - i);  // Trail to the left
                    segs[i].y <= CB'(`SNAKE_START_Y);
                end else begin
                    segs[i] <= '1;                      // Empty marker
                end
            end
        end else if (ctrl.move) begin
            segs[0] <= head;
            for (int i = 1; i < SEGS; i++) begin
                if (i < int'(length) - 1) segs[i] <= segs[i-1];
            end
        end
    end

    // Checks against active segments only
    always_comb begin
        self_hit = 1'b0;
        occupied = (query == head);
        for (int i = 0; i < SEGS; i++) begin
            if (i < int'(length) - 1) begin
                self_hit = self_hit | (segs[i] == head);
                occupied = occupied | (segs[i] == query);
            end
        end
    end

    // On a border cell and still heading into it
    assign wall_hit = (head.x == '0          && heading == HEAD_LEFT)  ||
                      (head.x == CB'(X_LAST) && heading == HEAD_RIGHT) ||
                      (head.y == '0          && heading == HEAD_UP)    ||
                      (head.y == CB'(Y_LAST) && heading == HEAD_DOWN);

    assign head_crash = self_hit | wall_hit;
    assign neck       = segs[0];

endmodule

`default_nettype wire

/* src/snake_steering.sv */
// Relative steering
// Turn request latch, one turn per move
// Heading register, clockwise for right, counter-clockwise for left
`timescale 1ns/1ps
`default_nettype none

module snake_steering (
    input  wire                        clock_25,
    input  wire                        reset,
    input  wire snake_pkg::turn_t      presses,
    input  wire snake_pkg::game_ctrl_t ctrl,
    input  wire                        started,
    input  wire snake_pkg::cell_t      head,
    input  wire snake_pkg::cell_t      neck,
    output snake_pkg::heading_t        heading
);

    import snake_pkg::*;

    turn_t    turn_req;     // Pending turn until the next move
    heading_t travel;       // Direction of the last step
    heading_t turned;

    // Pending turn
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            turn_req <= '0;
        end else if (ctrl.restart) begin
            turn_req <= '0;
        end else if (started && (presses.turn_right || presses.turn_left)) begin
            if (presses.turn_right && presses.turn_left) turn_req <= '0;  // Both cancel
            else                                         turn_req <= presses;
        end else if (ctrl.move) begin
            turn_req <= '0;                             // Turn used up
        end
    end

    // Travel direction from head against neck, heading if they coincide
    always_comb begin
        travel = heading;
        if (head.y == neck.y && head.x > neck.x)      travel = HEAD_RIGHT;
        else if (head.y == neck.y && head.x < neck.x) travel = HEAD_LEFT;
        else if (head.x == neck.x && head.y < neck.y) travel = HEAD_UP;
        else if (head.x == neck.x && head.y > neck.y) travel = HEAD_DOWN;
    end

    always_comb begin
        turned = travel;
        case (travel)
            HEAD_UP:    turned = turn_req.turn_right ? HEAD_RIGHT : HEAD_LEFT;
            HEAD_RIGHT: turned = turn_req.turn_right ? HEAD_DOWN  : HEAD_UP;
            HEAD_DOWN:  turned = turn_req.turn_right ? HEAD_LEFT  : HEAD_RIGHT;
            HEAD_LEFT:  turned = turn_req.turn_right ? HEAD_UP    : HEAD_DOWN;
            default:    turned = travel;
        endcase
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset)                                     heading <= HEAD_RIGHT;
        else if (ctrl.restart)                          heading <= HEAD_RIGHT;  // Start rightward
        else if (turn_req.turn_right || turn_req.turn_left) heading <= turned;
    end

endmodule

`default_nettype wire

/* src/snake_control.sv */
// Game state machine
// Sequencing of start, move, eat, fruit placement and game over
// Moore decode of the control strobes and status levels
`timescale 1ns/1ps
`default_nettype none

module snake_control (
    input  wire                   clock_25,
    input  wire                   reset,
    input  wire snake_pkg::turn_t presses,
    input  wire                   game_tick,
    input  wire                   head_crash,
    input  wire                   fruit_hit,
    input  wire                   fruit_bad,
    output snake_pkg::game_ctrl_t ctrl,
    output logic                  started,
    output logic                  game_over
);

    import snake_pkg::*;

    game_state_t state;
    game_state_t state_next;
    logic        any_press;

    assign any_press = presses.turn_right | presses.turn_left;  // Either button

    // Reset lands in RESET_IDLE so restart is issued once
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) state <= RESET_IDLE;
        else        state <= state_next;
    end

    always_comb begin
        state_next = state;                             // Hold by default
        case (state)
            RESET_IDLE:   state_next = IDLE;
            IDLE:         if (any_press) state_next = WAIT;    // Press only starts
            WAIT:         if (game_tick) state_next = MOVING;
            MOVING:       state_next = MOVE_DONE;
            MOVE_DONE: begin
                // Crash wins over eating
                if (head_crash)     state_next = COLLISION;
                else if (fruit_hit) state_next = EATEN_FRUIT;
                else                state_next = WAIT;
            end
            EATEN_FRUIT:  state_next = FRUIT_UPDATE;
            FRUIT_UPDATE: if (!fruit_bad) state_next = WAIT;   // One redraw per cycle
            COLLISION:    if (any_press) state_next = RESET_IDLE;
            default:      state_next = RESET_IDLE;
        endcase
    end

    // Moore outputs
    always_comb begin
        ctrl         = '0;
        ctrl.move    = (state == MOVING);
        ctrl.grow    = (state == EATEN_FRUIT);
        ctrl.place   = (state == FRUIT_UPDATE);
        ctrl.restart = (state == RESET_IDLE);
    end

    assign started   = state inside {WAIT, MOVING, MOVE_DONE, EATEN_FRUIT, FRUIT_UPDATE};
    assign game_over = (state == COLLISION);

    // Body and fruit logic assume strobes never overlap
    ctrl_onehot_a: assert property (@(posedge clock_25) disable iff (!reset)
        $onehot0(ctrl));

endmodule

`default_nettype wire

/* src/button_sync.sv */
// Button input stage
// Two-flop synchroniser for both turn buttons
// Registered rising-edge strobes
`timescale 1ns/1ps
`default_nettype none

module button_sync (
    input  wire              clock_25,
    input  wire              reset,
    input  wire              turn_right_button,
    input  wire              turn_left_button,
    output snake_pkg::turn_t presses
);

    // Bit 1 right button, bit 0 left button
    logic [1:0] raw_buttons;
    logic [1:0] stage_new;  // First flop, newer sample
    logic [1:0] stage_old;  // Second flop, older sample

    assign raw_buttons = {turn_right_button, turn_left_button};

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            stage_new <= '0;
            stage_old <= '0;
            presses   <= '0;
        end else begin
            stage_new <= raw_buttons;
            stage_old <= stage_new;
            // Rising edge, one cycle per press
            presses.turn_right <= stage_new[1] & ~stage_old[1];
            presses.turn_left  <= stage_new[0] & ~stage_old[0];
        end
    end

endmodule

`default_nettype wire

/* src/snake_pkg.sv */
// Shared game types
// Grid cell, heading, FSM state encoding
// Control strobes and turn strobes
`default_nettype none

`include "snake_cfg.svh"

package snake_pkg;

    // One grid cell
    typedef struct packed {
        logic [`SNAKE_COORD_BITS-1:0] x;    // Column
        logic [`SNAKE_COORD_BITS-1:0] y;    // Row, 0 is the top
    } cell_t;

    // Absolute travel direction
    typedef enum logic [1:0] {
        HEAD_UP    = 2'd0,
        HEAD_DOWN  = 2'd1,
        HEAD_LEFT  = 2'd2,
        HEAD_RIGHT = 2'd3
    } heading_t;

    // Game FSM states
    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        WAIT         = 3'd1,
        COLLISION    = 3'd2,
        MOVING       = 3'd3,
        MOVE_DONE    = 3'd4,
        EATEN_FRUIT  = 3'd5,
        FRUIT_UPDATE = 3'd6,
        RESET_IDLE   = 3'd7
    } game_state_t;

    // One-cycle strobes from the FSM, at most one high
    typedef struct packed {
        logic move;     // Step head and shift body
        logic grow;     // Length and score up, new candidate fruit
        logic place;    // Redraw fruit if bad
        logic restart;  // Back to start values
    } game_ctrl_t;

    // Button edge strobes
    typedef struct packed {
        logic turn_right;
        logic turn_left;
    } turn_t;

endpackage

`default_nettype wire

/* include/snake_cfg.svh */
// Game configuration macros
// Grid size and field widths
// Start cells of snake and fruit, length limits
// Score wrap value and random generator seeds
`ifndef SNAKE_CFG_SVH
`define SNAKE_CFG_SVH

// Playing field in cells
`define SNAKE_GRID_W      124   // Columns
`define SNAKE_GRID_H      81    // Rows
`define SNAKE_COORD_BITS  7     // Enough for both axes

// Snake length counts the head too
`define SNAKE_LEN_BITS    6
`define SNAKE_LEN_MAX     63    // Saturation point
`define SNAKE_START_LEN   6     // Head plus five segments

// Start cells
`define SNAKE_START_X     8
`define SNAKE_START_Y     40
`define FRUIT_START_X     9     // Right in front of the head
`define FRUIT_START_Y     40

// Score counts 0..99 then wraps
`define SCORE_WRAP        99

// Seeds of the two fruit generators, must be nonzero
`define FRUIT_SEED_X      28
`define FRUIT_SEED_Y      48

`endif
